//--- pong.f
source/pong_pkg.sv
source/game_state_if.sv
source/paddle_ctrl.sv
source/ball_motion.sv
source/score_keeper.sv
source/pixel_render.sv
source/pong_top.sv
testbench/clk_gen.sv
testbench/pong_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile the testbench with Verilator, then run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module pong_tb \
    -f pong.f \
    --Mdir obj_dir \
    -o pong_sim

# A $fatal in the testbench gives a non-zero exit status
./obj_dir/pong_sim

//--- source/ball_motion.sv
`timescale 1ns/1ps

module ball_motion import pong_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       frame_tick,
    input  logic       game_over,
    input  logic [1:0] diff,
    game_state_if.ball_src st,
    output logic       point_l,
    output logic       point_r
);

    // Ball centre
    coord_t     ball_x;
    coord_t     ball_y;
    // Direction, 1 means right or down
    logic       dir_x;
    logic       dir_y;
    // Horizontal step per frame
    logic [2:0] speed;
    logic       active;
    // Goal flags named after the scoring player
    logic       goal_l;
    logic       goal_r;
    // Bounce conditions
    logic       hit_top;
    logic       hit_bot;
    logic       hit_pad_l;
    logic       hit_pad_r;
    coord_t     next_x;
    coord_t     next_y;

    // Difficulty only speeds up the horizontal motion
    assign speed  = {1'b0, diff} + 3'd1;
    // Frozen once the match is decided
    assign active = frame_tick && !game_over;

    ////////////////////
    // Goal detection
    ////////////////////
    // Past the right paddle, point for the left player
    assign goal_l = ball_x > XPAD_R + PAD_W;
    // Past the left paddle, point for the right player
    assign goal_r = ball_x < XPAD_L - PAD_W;

    ////////////////////
    // Bounces
    ////////////////////
    // Walls
    assign hit_bot = dir_y && (ball_y + BALL_R + 1 == SCR_H);
    assign hit_top = !dir_y && (ball_y == BALL_R);

    // Paddle face reached exactly on this step, row inside the paddle
    assign hit_pad_r = dir_x && (ball_x + BALL_R + speed == XPAD_R) &&
                       in_pad_span(ball_y, st.pad_r_y);
    assign hit_pad_l = !dir_x && (ball_x == XPAD_L + BALL_R + speed) &&
                       in_pad_span(ball_y, st.pad_l_y);

    // One step along the current directions
    always_comb begin
        if (dir_x) begin
            next_x = ball_x + coord_t'(speed);
        end else if (ball_x < coord_t'(speed)) begin
            // Saturate at column 0 rather than wrap to the far side
            next_x = '0;
        end else begin
            next_x = ball_x - coord_t'(speed);
        end
        next_y = dir_y ? ball_y + 7'd1 : ball_y - 7'd1;
    end

    ////////////////////
    // Ball state
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ball_x  <= coord_t'(X_MID);
            ball_y  <= coord_t'(Y_MID);
            dir_x   <= 1'b1;
            dir_y   <= 1'b1;
            point_l <= 1'b0;
            point_r <= 1'b0;
        end else begin
            // Point pulse lasts the single cycle after the tick
            point_l <= active && goal_l;
            point_r <= active && goal_r;
            if (active) begin
                if (goal_l || goal_r) begin
                    // Serve again from the centre, same directions
                    ball_x <= coord_t'(X_MID);
                    ball_y <= coord_t'(Y_MID);
                end else begin
                    ball_x <= next_x;
                    ball_y <= next_y;
                    if (hit_top || hit_bot) begin
                        dir_y <= !dir_y;
                    end
                    if (hit_pad_l || hit_pad_r) begin
                        dir_x <= !dir_x;
                    end
                end
            end
        end
    end

    assign st.ball_x = ball_x;
    assign st.ball_y = ball_y;

    // Only one side can score per frame
    a_one_point: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(point_l && point_r)
    ) else $error("both players scored together");

endmodule

//--- source/game_state_if.sv
`timescale 1ns/1ps

interface game_state_if import pong_pkg::*; ();

    // Ball centre
    coord_t ball_x;
    coord_t ball_y;
    // Paddle centres, vertical only
    coord_t pad_l_y;
    coord_t pad_r_y;

    // Paddle decoder owns both paddle rows
    modport paddle_src (
        output pad_l_y,
        output pad_r_y
    );

    // Ball block owns the ball, needs paddles for bounces
    modport ball_src (
        output ball_x,
        output ball_y,
        input  pad_l_y,
        input  pad_r_y
    );

    // Renderer only looks
    modport viewer (
        input ball_x,
        input ball_y,
        input pad_l_y,
        input pad_r_y
    );

endinterface

//--- source/paddle_ctrl.sv
`timescale 1ns/1ps

module paddle_ctrl import pong_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic frame_tick,
    input  logic btn_l_up,
    input  logic btn_l_dn,
    input  logic btn_r_up,
    input  logic btn_r_dn,
    game_state_if.paddle_src st
);

    // One frame of paddle travel for a single player
    // Up is towards row 0, both buttons together cancel
    function automatic coord_t pad_step(coord_t pos, logic up, logic dn);
        int pos_nx;
        pos_nx = int'(pos);
        if (up && !dn) begin
            pos_nx = int'(pos) - PAD_STEP;
        end else if (dn && !up) begin
            pos_nx = int'(pos) + PAD_STEP;
        end
        // Keep the whole paddle on screen
        if (pos_nx < PAD_MIN) begin
            pos_nx = PAD_MIN;
        end else if (pos_nx > PAD_MAX) begin
            pos_nx = PAD_MAX;
        end
        return coord_t'(pos_nx);
    endfunction

    ////////////////////
    // Paddle registers
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Both paddles start centred
            st.pad_l_y <= coord_t'(Y_MID);
            st.pad_r_y <= coord_t'(Y_MID);
        end else if (frame_tick) begin
            st.pad_l_y <= pad_step(st.pad_l_y, btn_l_up, btn_l_dn);
            st.pad_r_y <= pad_step(st.pad_r_y, btn_r_up, btn_r_dn);
        end
    end

    // Paddles never leave the clamp window
    a_pad_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (st.pad_l_y >= PAD_MIN) && (st.pad_l_y <= PAD_MAX) &&
        (st.pad_r_y >= PAD_MIN) && (st.pad_r_y <= PAD_MAX)
    ) else $error("paddle outside clamp range");

endmodule

//--- source/pixel_render.sv
`timescale 1ns/1ps

module pixel_render import pong_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    game_state_if.viewer st,
    input  logic      pix_valid,
    output logic      pix_ready,
    input  coord_t    pix_x,
    input  coord_t    pix_y,
    output logic      kind_valid,
    input  logic      kind_ready,
    output pix_kind_t kind
);

    // Stage 1
    logic      s1_valid;
    coord_t    s1_x;
    coord_t    s1_y;
    logic      s1_ball;
    logic      s1_pad;
    // Handshake
    logic      s2_ready;
    logic      s1_load;
    // Hit tests on the incoming query
    logic      in_ball;
    logic      in_pad;
    logic      s1_net;
    pix_kind_t kind_nx;

    // Output stage frees up when empty or being taken
    assign s2_ready  = !kind_valid || kind_ready;
    assign pix_ready = !s1_valid || s2_ready;
    assign s1_load   = pix_valid && pix_ready;

    ////////////////////
    // Hit tests
    ////////////////////
    // Strictly inside the ball square, written without subtraction
    assign in_ball = (pix_x + BALL_R > st.ball_x) && (pix_x < st.ball_x + BALL_R) &&
                     (pix_y + BALL_R > st.ball_y) && (pix_y < st.ball_y + BALL_R);

    // Either paddle, column band and row span
    assign in_pad = ((pix_x >= XPAD_L) && (pix_x < XPAD_L + PAD_W) &&
                     in_pad_span(pix_y, st.pad_l_y)) ||
                    ((pix_x >= XPAD_R) && (pix_x < XPAD_R + PAD_W) &&
                     in_pad_span(pix_y, st.pad_r_y));

    // Stage 1 valid, holds while stage 2 is stalled
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else if (pix_ready) begin
            s1_valid <= pix_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_load) begin
            s1_x    <= pix_x;
            s1_y    <= pix_y;
            s1_ball <= in_ball;
            s1_pad  <= in_pad;
        end
    end

    ////////////////////
    // Priority resolve
    ////////////////////
    // Dashed net, 4 rows on and 4 off
    assign s1_net = (s1_x == NET_X) && !s1_y[2];

    always_comb begin
        if (s1_ball) begin
            kind_nx = PIX_BALL;
        end else if (s1_pad) begin
            kind_nx = PIX_PADDLE;
        end else if (s1_net) begin
            kind_nx = PIX_NET;
        end else begin
            kind_nx = PIX_BG;
        end
    end

    // Stage 2 valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            kind_valid <= 1'b0;
        end else if (s2_ready) begin
            kind_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s2_ready && s1_valid) begin
            kind <= kind_nx;
        end
    end

    // Result stays put while the consumer stalls
    a_kind_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (kind_valid && !kind_ready) |=> (kind_valid && $stable(kind))
    ) else $error("kind changed under back-pressure");

endmodule

//--- source/pong_pkg.sv
package pong_pkg;

    ////////////////////
    // Screen geometry
    ////////////////////
    localparam int SCR_W   = 96;
    localparam int SCR_H   = 64;
    localparam int COORD_W = 7;
    // Centre of the field, used for serve and paddle home
    localparam int X_MID   = SCR_W / 2;
    localparam int Y_MID   = SCR_H / 2;
    // Net sits on the centre column
    localparam int NET_X   = SCR_W / 2;

    ////////////////////
    // Game objects
    ////////////////////
    localparam int BALL_R   = 2;
    localparam int PAD_W    = 2;
    localparam int PAD_H    = 20;
    // Leftmost column of each paddle
    localparam int XPAD_L   = 4;
    localparam int XPAD_R   = 91;
    // Paddle travel per frame and centre clamp range
    localparam int PAD_STEP = 2;
    localparam int PAD_MIN  = 10;
    localparam int PAD_MAX  = 53;

    // Scoring
    localparam int SCORE_W   = 4;
    localparam int WIN_SCORE = 7;

    typedef logic [COORD_W-1:0] coord_t;
    typedef logic [SCORE_W-1:0] score_t;

    // Renderer output classes
    typedef enum logic [1:0] {
        PIX_BG     = 2'd0,
        PIX_NET    = 2'd1,
        PIX_PADDLE = 2'd2,
        PIX_BALL   = 2'd3
    } pix_kind_t;

    // Row y lies within a paddle centred at pad, ends included
    function automatic logic in_pad_span(coord_t y, coord_t pad);
        return (y + PAD_H / 2 >= pad) && (y <= pad + PAD_H / 2);
    endfunction

endpackage

//--- source/pong_top.sv
`timescale 1ns/1ps

module pong_top import pong_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       frame_tick,
    // Player buttons
    input  logic       btn_l_up,
    input  logic       btn_l_dn,
    input  logic       btn_r_up,
    input  logic       btn_r_dn,
    input  logic [1:0] diff,
    // Pixel query in
    input  logic       pix_valid,
    output logic       pix_ready,
    input  coord_t     pix_x,
    input  coord_t     pix_y,
    // Pixel class out
    output logic       kind_valid,
    input  logic       kind_ready,
    output pix_kind_t  kind,
    // Match status
    output score_t     score_l,
    output score_t     score_r,
    output logic       game_over
);

    // Point pulses, ball to scoring
    logic point_l;
    logic point_r;

    // Shared ball and paddle positions
    game_state_if st ();

    ////////////////////
    // Decode
    ////////////////////
    paddle_ctrl u_paddle_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .frame_tick (frame_tick),
        .btn_l_up   (btn_l_up),
        .btn_l_dn   (btn_l_dn),
        .btn_r_up   (btn_r_up),
        .btn_r_dn   (btn_r_dn),
        .st         (st.paddle_src)
    );

    ////////////////////
    // Execute
    ////////////////////
    ball_motion u_ball_motion (
        .clk        (clk),
        .rst_n      (rst_n),
        .frame_tick (frame_tick),
        .game_over  (game_over),
        .diff       (diff),
        .st         (st.ball_src),
        .point_l    (point_l),
        .point_r    (point_r)
    );

    ////////////////////
    // Result
    ////////////////////
    score_keeper u_score_keeper (
        .clk       (clk),
        .rst_n     (rst_n),
        .point_l   (point_l),
        .point_r   (point_r),
        .score_l   (score_l),
        .score_r   (score_r),
        .game_over (game_over)
    );

    pixel_render u_pixel_render (
        .clk        (clk),
        .rst_n      (rst_n),
        .st         (st.viewer),
        .pix_valid  (pix_valid),
        .pix_ready  (pix_ready),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .kind_valid (kind_valid),
        .kind_ready (kind_ready),
        .kind       (kind)
    );

endmodule

//--- source/score_keeper.sv
`timescale 1ns/1ps

module score_keeper import pong_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   point_l,
    input  logic   point_r,
    output score_t score_l,
    output score_t score_r,
    output logic   game_over
);

    // Scores after this cycle's pulse
    score_t score_l_nx;
    score_t score_r_nx;
    logic   win;

    // No more points once the match is over
    assign score_l_nx = score_l + SCORE_W'(point_l && !game_over);
    assign score_r_nx = score_r + SCORE_W'(point_r && !game_over);

    // Either player reaching the target ends it
    assign win = (score_l_nx == WIN_SCORE) || (score_r_nx == WIN_SCORE);

    ////////////////////
    // Score registers
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            score_l <= '0;
            score_r <= '0;
        end else begin
            score_l <= score_l_nx;
            score_r <= score_r_nx;
        end
    end

    // Sticky until reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            game_over <= 1'b0;
        end else if (win) begin
            game_over <= 1'b1;
        end
    end

    // Count stops at the winning score
    a_score_cap: assert property (
        @(posedge clk) disable iff (!rst_n)
        (score_l <= WIN_SCORE) && (score_r <= WIN_SCORE)
    ) else $error("score above winning score");

endmodule

//--- testbench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam int PERIOD_NS    = 8;
    localparam int RESET_CYCLES = 8;

    // Free-running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset held low, released just after an edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

//--- testbench/pong_tb.sv
`timescale 1ns/1ps

module pong_tb import pong_pkg::*; ();

    localparam int          CLK_NS    = 8;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic      clk;
    logic      rst_n;
    logic      frame_tick;
    logic      btn_l_up;
    logic      btn_l_dn;
    logic      btn_r_up;
    logic      btn_r_dn;
    logic [1:0] diff;
    logic      pix_valid;
    logic      pix_ready;
    coord_t    pix_x;
    coord_t    pix_y;
    logic      kind_valid;
    logic      kind_ready;
    pix_kind_t kind;
    score_t    score_l;
    score_t    score_r;
    logic      game_over;

    // Reference model of ball, paddles and scores
    int          m_bx;
    int          m_by;
    logic        m_dx;
    logic        m_dy;
    int          m_pl;
    int          m_pr;
    int          m_sl;
    int          m_sr;
    logic        m_over;
    logic [31:0] lfsr_state;
    // Burst queries, expected kinds, input transfer times
    coord_t      qx[$];
    coord_t      qy[$];
    pix_kind_t   exp_q[$];
    time         xfer_q[$];

    clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    pong_top u_dut (
        .clk(clk), .rst_n(rst_n), .frame_tick(frame_tick),
        .btn_l_up(btn_l_up), .btn_l_dn(btn_l_dn),
        .btn_r_up(btn_r_up), .btn_r_dn(btn_r_dn), .diff(diff),
        .pix_valid(pix_valid), .pix_ready(pix_ready), .pix_x(pix_x), .pix_y(pix_y),
        .kind_valid(kind_valid), .kind_ready(kind_ready), .kind(kind),
        .score_l(score_l), .score_r(score_r), .game_over(game_over)
    );

    ////////////////////
    // Failure reporting
    ////////////////////
    task automatic end_in_failure();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic value_error(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        end_in_failure();
    endtask

    task automatic timeout_error(input string msg);
        $display("Timed out at %0t ns: %s", $time, msg);
        end_in_failure();
    endtask

    task automatic check_kind(input pix_kind_t got, input pix_kind_t exp, input string what);
        if (got !== exp)
            value_error($sformatf("%s: got %s, expected %s", what, got.name(), exp.name()));
    endtask

    task automatic check_score(input score_t got, input score_t exp, input string what);
        if (got !== exp)
            value_error($sformatf("%s: got %0d, expected %0d", what, got, exp));
    endtask

    // Galois LFSR, one step per bit
    function automatic logic rand_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) lfsr_state = lfsr_state ^ LFSR_TAPS;
        return lsb;
    endfunction

    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) r = (r << 1) | int'(rand_bit());
        return r;
    endfunction

    ////////////////////
    // Reference model
    ////////////////////
    function automatic logic near_pad(input int y, input int pad);
        return (y >= pad - PAD_H / 2) && (y <= pad + PAD_H / 2);
    endfunction

    function automatic int pad_move(input int p, input logic up, input logic dn);
        int q;
        q = p;
        if (up && !dn) q = p - PAD_STEP;
        else if (dn && !up) q = p + PAD_STEP;
        if (q < PAD_MIN) q = PAD_MIN;
        if (q > PAD_MAX) q = PAD_MAX;
        return q;
    endfunction

    // Expected class of one pixel from the model state
    function automatic pix_kind_t classify(input int x, input int y);
        int   dx;
        int   dy;
        logic pad;
        dx = (x > m_bx) ? x - m_bx : m_bx - x;
        dy = (y > m_by) ? y - m_by : m_by - y;
        pad = (x >= XPAD_L && x < XPAD_L + PAD_W && near_pad(y, m_pl)) ||
              (x >= XPAD_R && x < XPAD_R + PAD_W && near_pad(y, m_pr));
        if (dx < BALL_R && dy < BALL_R) return PIX_BALL;
        if (pad) return PIX_PADDLE;
        if (x == SCR_W / 2 && ((y >> 2) & 1) == 0) return PIX_NET;
        return PIX_BG;
    endfunction

    // All rules read the state from before the tick
    task automatic model_frame(input logic lu, ld, ru, rd, input logic [1:0] d);
        int   s;
        logic flip_x;
        logic flip_y;
        s = 1 + d;
        if (!m_over) begin
            if (m_bx < XPAD_L - PAD_W || m_bx > XPAD_R + PAD_W) begin
                if (m_bx < XPAD_L - PAD_W) m_sr++;
                else m_sl++;
                m_bx = SCR_W / 2;
                m_by = SCR_H / 2;
            end else begin
                flip_y = m_dy ? (m_by + BALL_R + 1 == SCR_H) : (m_by == BALL_R);
                flip_x = m_dx ? (m_bx + BALL_R + s == XPAD_R && near_pad(m_by, m_pr))
                              : (m_bx - BALL_R - s == XPAD_L && near_pad(m_by, m_pl));
                // Ball stops at the left screen edge
                if (m_dx) m_bx = m_bx + s;
                else m_bx = (m_bx < s) ? 0 : m_bx - s;
                m_by = m_dy ? m_by + 1 : m_by - 1;
                if (flip_y) m_dy = !m_dy;
                if (flip_x) m_dx = !m_dx;
            end
            m_over = (m_sl == WIN_SCORE) || (m_sr == WIN_SCORE);
        end
        m_pl = pad_move(m_pl, lu, ld);
        m_pr = pad_move(m_pr, ru, rd);
    endtask

    ////////////////////
    // Stimulus helpers
    ////////////////////
    // One tick, then two cycles for point pulse and score update
    task automatic frame(input logic lu, ld, ru, rd, input logic [1:0] d);
        btn_l_up   = lu;
        btn_l_dn   = ld;
        btn_r_up   = ru;
        btn_r_dn   = rd;
        diff       = d;
        frame_tick = 1'b1;
        @(posedge clk);
        #1;
        frame_tick = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        model_frame(lu, ld, ru, rd, d);
        check_score(score_l, score_t'(m_sl), "left score");
        check_score(score_r, score_t'(m_sr), "right score");
        if (game_over !== m_over)
            value_error($sformatf("game_over is %b, expected %b", game_over, m_over));
    endtask

    // Single query with the consumer always ready
    task automatic query(input int x, input int y, output pix_kind_t k);
        int n;
        pix_valid = 1'b1;
        pix_x     = coord_t'(x);
        pix_y     = coord_t'(y);
        n = 0;
        while (!pix_ready) begin
            @(posedge clk);
            #1;
            n++;
            if (n > 20) timeout_error("pixel query never accepted");
        end
        @(posedge clk);
        #1;
        pix_valid = 1'b0;
        n = 0;
        while (!kind_valid) begin
            @(posedge clk);
            #1;
            n++;
            if (n > 20) timeout_error("pixel result never arrived");
        end
        k = kind;
        @(posedge clk);
        #1;
    endtask

    task automatic check_pixel(input int x, input int y);
        pix_kind_t k;
        if (x < 0 || y < 0) return;
        query(x, y, k);
        check_kind(k, classify(x, y), $sformatf("pixel (%0d,%0d)", x, y));
    endtask

    // 3x3 core of the ball plus a few neighbours
    task automatic check_ball_area();
        pix_kind_t k;
        for (int dy = -1; dy <= 1; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
                if (m_bx + dx >= 0) begin
                    query(m_bx + dx, m_by + dy, k);
                    check_kind(k, PIX_BALL, $sformatf("ball pixel (%0d,%0d)",
                               m_bx + dx, m_by + dy));
                end
            end
        end
        check_pixel(m_bx + 2, m_by);
        check_pixel(m_bx - 2, m_by);
        check_pixel(m_bx, m_by + 2);
    endtask

    // Paddle ends and the rows just outside them
    task automatic check_paddles();
        check_pixel(XPAD_L, m_pl - PAD_H / 2 - 1);
        check_pixel(XPAD_L, m_pl - PAD_H / 2);
        check_pixel(XPAD_L + 1, m_pl + PAD_H / 2);
        check_pixel(XPAD_L + 1, m_pl + PAD_H / 2 + 1);
        check_pixel(XPAD_R, m_pr - PAD_H / 2 - 1);
        check_pixel(XPAD_R, m_pr - PAD_H / 2);
        check_pixel(XPAD_R + 1, m_pr + PAD_H / 2);
        check_pixel(XPAD_R + 1, m_pr + PAD_H / 2 + 1);
    endtask

    // Mix of ball, paddle and random pixels
    task automatic fill_queries(input int count);
        int x;
        int y;
        qx.delete();
        qy.delete();
        for (int i = 0; i < count; i++) begin
            if (i % 4 == 0) begin
                x = m_bx - 2 + rand_bits(3) % 5;
                y = m_by - 2 + rand_bits(3) % 5;
            end else if (i % 4 == 1) begin
                x = rand_bit() ? XPAD_L : XPAD_R;
                x = x + rand_bit();
                y = rand_bits(6);
            end else begin
                x = rand_bits(7) % 100;
                y = rand_bits(6);
            end
            if (x < 0) x = 0;
            qx.push_back(coord_t'(x));
            qy.push_back(coord_t'(y));
            exp_q.push_back(classify(x, y));
        end
    endtask

    // Handshake signals sampled 2 ns after the edge
    task automatic send_all();
        int   n;
        logic accept;
        foreach (qx[i]) begin
            pix_valid = 1'b1;
            pix_x     = qx[i];
            pix_y     = qy[i];
            accept = 1'b0;
            n = 0;
            while (!accept) begin
                #1;
                accept = pix_ready;
                @(posedge clk);
                if (accept) xfer_q.push_back($time);
                #1;
                n++;
                if (n > 200) timeout_error("burst query stuck without pix_ready");
            end
        end
        pix_valid = 1'b0;
    endtask

    task automatic collect_all(input logic stalls);
        int        total;
        int        got;
        int        n;
        logic      take;
        pix_kind_t k;
        time       t_in;
        total = exp_q.size();
        got = 0;
        n = 0;
        while (got < total) begin
            kind_ready = stalls ? rand_bit() : 1'b1;
            #1;
            take = kind_valid && kind_ready;
            k = kind;
            @(posedge clk);
            if (take) begin
                t_in = xfer_q.pop_front();
                check_kind(k, exp_q.pop_front(), $sformatf("burst result %0d", got));
                if (!stalls && ($time - t_in != 2 * CLK_NS))
                    value_error($sformatf("burst result %0d took %0t ns", got, $time - t_in));
                got++;
            end
            #1;
            n++;
            if (n > 1000) timeout_error("burst results stopped arriving");
        end
        kind_ready = 1'b1;
    endtask

    ////////////////////
    // Tests
    ////////////////////
    task automatic reset_state_test();
        check_score(score_l, '0, "left score after reset");
        check_score(score_r, '0, "right score after reset");
        if (game_over !== 1'b0) value_error("game_over high after reset");
        if (pix_ready !== 1'b1) value_error("pix_ready low after reset");
        if (kind_valid !== 1'b0) value_error("kind_valid high after reset");
        check_ball_area();
        check_paddles();
        // Net dashes on the centre column
        check_pixel(SCR_W / 2, 0);
        check_pixel(SCR_W / 2, 4);
        check_pixel(SCR_W / 2, 40);
        check_pixel(SCR_W / 2, 44);
        check_pixel(20, 50);
    endtask

    task automatic paddle_decode_test();
        logic lu;
        logic ld;
        logic ru;
        logic rd;
        repeat (60) begin
            lu = rand_bit();
            ld = rand_bit();
            ru = rand_bit();
            rd = rand_bit();
            frame(lu, ld, ru, rd, 2'd0);
            check_paddles();
        end
        // Long holds run into the clamps
        repeat (30) begin
            frame(1'b1, 1'b0, 1'b0, 1'b1, 2'd0);
            check_paddles();
        end
        repeat (30) begin
            frame(1'b0, 1'b1, 1'b1, 1'b0, 2'd0);
            check_paddles();
        end
    endtask

    // Paddles chase the ball so both faces get hit at speed 1
    task automatic ball_execute_test();
        for (int d = 0; d < 4; d++) begin
            repeat ((d == 0) ? 100 : 16) begin
                frame(m_pl > m_by, m_pl < m_by, m_pr > m_by, m_pr < m_by, 2'(d));
                check_ball_area();
            end
        end
    endtask

    task automatic scoring_test();
        int   n;
        int   sl;
        int   sr;
        logic park;
        logic lu;
        logic rd;
        n = 0;
        // Paddles parked on the far side from the ball
        while (!m_over) begin
            park = (m_by >= SCR_H / 2);
            frame(park, !park, park, !park, 2'd3);
            check_ball_area();
            n++;
            if (n > 200) timeout_error("game over never reached");
        end
        sl = m_sl;
        sr = m_sr;
        repeat (8) begin
            lu = rand_bit();
            rd = rand_bit();
            frame(lu, !lu, !rd, rd, 2'd3);
            check_ball_area();
        end
        check_score(score_l, score_t'(sl), "left score after game over");
        check_score(score_r, score_t'(sr), "right score after game over");
    endtask

    task automatic pixel_pipeline_test();
        fill_queries(40);
        fork
            send_all();
            collect_all(1'b1);
        join
        // No stalls, fixed latency expected
        fill_queries(40);
        fork
            send_all();
            collect_all(1'b0);
        join
    endtask

    initial begin
        int n;
        lfsr_state = 32'h6f0a9ed3;
        frame_tick = 1'b0;
        btn_l_up   = 1'b0;
        btn_l_dn   = 1'b0;
        btn_r_up   = 1'b0;
        btn_r_dn   = 1'b0;
        diff       = 2'd0;
        pix_valid  = 1'b0;
        pix_x      = '0;
        pix_y      = '0;
        kind_ready = 1'b1;
        // Model starts like the DUT after reset
        m_bx   = SCR_W / 2;
        m_by   = SCR_H / 2;
        m_dx   = 1'b1;
        m_dy   = 1'b1;
        m_pl   = SCR_H / 2;
        m_pr   = SCR_H / 2;
        m_sl   = 0;
        m_sr   = 0;
        m_over = 1'b0;
        n = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            n++;
            if (n > 20) timeout_error("reset never released");
        end
        @(posedge clk);
        #1;
        reset_state_test();
        paddle_decode_test();
        ball_execute_test();
        scoring_test();
        pixel_pipeline_test();
        $display("RESULT: PASS");
        $finish;
    end

endmodule
